// ==== design/key_debounce.sv ====
`timescale 1ns/1ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 1000
) (
    input  logic clk_50M,
    input  logic rst_n,
    input  logic key_raw,
    output logic release_pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync;
    logic             key_level;
    logic [CNT_W-1:0] cnt;
    logic             flip;

    // raw key is active low and not related to clk_50M
    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], key_raw};
        end
    end

    // last cycle of a stable difference
    assign flip = (sync[1] != key_level) && (cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            key_level     <= 1'b1;
            cnt           <= '0;
            release_pulse <= 1'b0;
        end else begin
            release_pulse <= flip && sync[1];
            if (sync[1] == key_level || flip) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            if (flip) begin
                key_level <= sync[1];
            end
        end
    end

endmodule

// ==== design/menu_ctrl.sv ====
`timescale 1ns/1ps

module menu_ctrl (
    input  logic               clk_50M,
    input  logic               rst_n,
    input  ui_pkg::key_evt_t   evt,
    output ui_pkg::menu_mode_t mode,
    output ui_pkg::sel2_t      cursor
);

    import ui_pkg::*;

    localparam sel2_t LAST_ENTRY = sel2_t'(TOP_ENTRIES - 1);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            mode   <= MODE_TOP;
            cursor <= '0;
        end else begin
            case (mode)
                MODE_TOP: begin
                    if (evt.confirm) begin
                        // cursor position picks the sub-mode
                        case (cursor)
                            2'd0: mode <= MODE_SIGGEN;
                            2'd1: mode <= MODE_SCOPE;
                            default: mode <= MODE_TOP;
                        endcase
                    end else if (evt.left) begin
                        if (cursor == '0) begin
                            cursor <= LAST_ENTRY;
                        end else begin
                            cursor <= cursor - 1'b1;
                        end
                    end else if (evt.right) begin
                        if (cursor == LAST_ENTRY) begin
                            cursor <= '0;
                        end else begin
                            cursor <= cursor + 1'b1;
                        end
                    end
                end
                MODE_SIGGEN, MODE_SCOPE: begin
                    if (evt.quit) begin
                        mode   <= MODE_TOP;
                        cursor <= '0;
                    end
                end
                default: begin
                    mode   <= MODE_TOP;
                    cursor <= '0;
                end
            endcase
        end
    end

endmodule

// ==== design/scope_panel.sv ====
`timescale 1ns/1ps

module scope_panel (
    input  logic               clk_50M,
    input  logic               rst_n,
    input  ui_pkg::key_evt_t   evt,
    input  ui_pkg::menu_mode_t mode,
    output ui_pkg::scope_cfg_t cfg
);

    import ui_pkg::*;

    localparam sel2_t ZOOM_MAX = sel2_t'(ZOOM_STEPS - 1);

    function automatic sel2_t zoom_inc(sel2_t z);
        return (z == ZOOM_MAX) ? '0 : z + 1'b1;
    endfunction

    function automatic sel2_t zoom_dec(sel2_t z);
        return (z == '0) ? ZOOM_MAX : z - 1'b1;
    endfunction

    always_ff @(posedge clk_50M) begin
        if (!rst_n || mode != MODE_SCOPE) begin
            cfg <= '0;
        end else if (evt.confirm || cfg.fft_on) begin
            // spectrum view holds both zooms at 0
            cfg.fft_on <= 1'b1;
            cfg.v_zoom <= '0;
            cfg.h_zoom <= '0;
        end else begin
            if (evt.up) begin
                cfg.v_zoom <= zoom_inc(cfg.v_zoom);
            end else if (evt.down) begin
                cfg.v_zoom <= zoom_dec(cfg.v_zoom);
            end
            if (evt.left) begin
                cfg.h_zoom <= zoom_dec(cfg.h_zoom);
            end else if (evt.right) begin
                cfg.h_zoom <= zoom_inc(cfg.h_zoom);
            end
        end
    end

endmodule

// ==== design/siggen_panel.sv ====
`timescale 1ns/1ps

module siggen_panel (
    input  logic                clk_50M,
    input  logic                rst_n,
    input  ui_pkg::key_evt_t    evt,
    input  ui_pkg::menu_mode_t  mode,
    output ui_pkg::siggen_cfg_t cfg
);

    import ui_pkg::*;

    localparam row_t START_ROW = row_t'(LAST_ROW);

    // left decrements and right increments, wrapping over 0..3
    function automatic sel2_t step_sel(sel2_t v, key_evt_t e);
        if (e.left) begin
            return v - 1'b1;
        end else if (e.right) begin
            return v + 1'b1;
        end
        return v;
    endfunction

    always_ff @(posedge clk_50M) begin
        if (!rst_n || mode != MODE_SIGGEN) begin
            cfg <= '0;
        end else begin
            // up moves toward row 0
            if (evt.up) begin
                if (cfg.row == '0) begin
                    cfg.row <= START_ROW;
                end else begin
                    cfg.row <= cfg.row - 1'b1;
                end
            end else if (evt.down) begin
                if (cfg.row == START_ROW) begin
                    cfg.row <= '0;
                end else begin
                    cfg.row <= cfg.row + 1'b1;
                end
            end

            case (cfg.row)
                3'd0: cfg.wave <= step_sel(cfg.wave, evt);
                3'd1: cfg.amp <= step_sel(cfg.amp, evt);
                3'd2: cfg.freq <= step_sel(cfg.freq, evt);
                3'd3: cfg.phase <= step_sel(cfg.phase, evt);
                default: begin
                    // start row, run stays set until the mode is left
                    if (evt.confirm) begin
                        cfg.run <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/ui_pkg.sv ====
package ui_pkg;

    localparam int TOP_ENTRIES    = 2;
    localparam int LAST_ROW       = 4;
    localparam int ZOOM_STEPS     = 3;
    // accumulator increment at freq 0
    localparam int FREQ_BASE_STEP = 64;

    typedef logic [1:0]  sel2_t;
    typedef logic [2:0]  row_t;
    typedef logic [7:0]  sample_t;
    typedef logic [15:0] phase_t;

    typedef enum logic [1:0] {
        MODE_TOP    = 2'd0,
        MODE_SIGGEN = 2'd1,
        MODE_SCOPE  = 2'd2
    } menu_mode_t;

    // one-cycle release pulses
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic confirm;
        logic quit;
    } key_evt_t;

    // row 4 is the start row
    typedef struct packed {
        row_t  row;
        sel2_t wave;
        sel2_t amp;
        sel2_t freq;
        sel2_t phase;
        logic  run;
    } siggen_cfg_t;

    typedef struct packed {
        sel2_t v_zoom;
        sel2_t h_zoom;
        logic  fft_on;
    } scope_cfg_t;

endpackage

// ==== design/ui_top.sv ====
`timescale 1ns/1ps

module ui_top #(
    parameter int DEBOUNCE_CYCLES = 1000
) (
    input  logic                clk_50M,
    input  logic                rst_n,
    // active low, bit 0 left up to bit 5 quit
    input  logic [5:0]          key_in,
    output ui_pkg::menu_mode_t  mode,
    output ui_pkg::sel2_t       cursor,
    output ui_pkg::siggen_cfg_t siggen_cfg,
    output ui_pkg::scope_cfg_t  scope_cfg,
    output ui_pkg::sample_t     da_data
);

    import ui_pkg::*;

    logic [5:0] rel;
    key_evt_t   evt;

    for (genvar i = 0; i < 6; i++) begin : g_key
        key_debounce #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) u_key (
            .clk_50M      (clk_50M),
            .rst_n        (rst_n),
            .key_raw      (key_in[i]),
            .release_pulse(rel[i])
        );
    end

    assign evt = '{
        left:    rel[0],
        right:   rel[1],
        up:      rel[2],
        down:    rel[3],
        confirm: rel[4],
        quit:    rel[5]
    };

    menu_ctrl u_menu (.clk_50M(clk_50M), .rst_n(rst_n), .evt(evt), .mode(mode), .cursor(cursor));

    // both panels run side by side
    siggen_panel u_siggen (.clk_50M(clk_50M), .rst_n(rst_n), .evt(evt), .mode(mode),
                           .cfg(siggen_cfg));

    scope_panel u_scope (.clk_50M(clk_50M), .rst_n(rst_n), .evt(evt), .mode(mode),
                         .cfg(scope_cfg));

    wave_dds u_dds (.clk_50M(clk_50M), .rst_n(rst_n), .cfg(siggen_cfg), .sample(da_data));

endmodule

// ==== design/wave_dds.sv ====
`timescale 1ns/1ps

module wave_dds (
    input  logic                clk_50M,
    input  logic                rst_n,
    input  ui_pkg::siggen_cfg_t cfg,
    output ui_pkg::sample_t     sample
);

    import ui_pkg::*;

    logic    active;
    phase_t  acc;
    phase_t  step;
    phase_t  ph_off;
    sample_t top_byte;
    sample_t shaped;

    assign step = phase_t'(FREQ_BASE_STEP) << cfg.freq;

    // one phase step is a quarter turn
    assign ph_off   = acc + {cfg.phase, 14'd0};
    assign top_byte = ph_off[15:8];

    always_comb begin
        case (cfg.wave)
            2'd0: shaped = top_byte;
            2'd1: shaped = ~top_byte;
            // fold the second half back down
            2'd2: shaped = top_byte[7] ? ~{top_byte[6:0], 1'b0} : {top_byte[6:0], 1'b0};
            default: shaped = {8{top_byte[7]}};
        endcase
    end

    // accumulator starts one cycle after run rises
    always_ff @(posedge clk_50M) begin
        if (!rst_n || !cfg.run) begin
            active <= 1'b0;
            acc    <= '0;
            sample <= '0;
        end else begin
            active <= 1'b1;
            if (active) begin
                acc    <= acc + step;
                sample <= shaped >> cfg.amp;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ui_top -f vlog.f -o sim_ui_top \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_ui_top 2>&1)"
echo "$out"
echo "$out" | grep -qx ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== test/tb_ui_top.sv ====
`timescale 1ns/1ps

module tb_ui_top;

    import ui_pkg::*;

    localparam int N_EVENTS       = 300;
    localparam int PRESS_CYCLES   = 12;
    localparam int IDLE_CYCLES    = 12;
    localparam int TIMEOUT_CYCLES = N_EVENTS * (PRESS_CYCLES + IDLE_CYCLES) + 200;

    // key_in bit positions
    localparam int K_LEFT    = 0;
    localparam int K_RIGHT   = 1;
    localparam int K_UP      = 2;
    localparam int K_DOWN    = 3;
    localparam int K_CONFIRM = 4;
    localparam int K_QUIT    = 5;

    logic        clk_50M;
    logic        rst_n;
    logic [5:0]  key_in;
    menu_mode_t  mode;
    sel2_t       cursor;
    siggen_cfg_t siggen_cfg;
    scope_cfg_t  scope_cfg;
    sample_t     da_data;

    integer seed;
    int     cycle_count = 0;
    int     error_count = 0;

    // menu and panel model
    menu_mode_t m_mode;
    int         m_cursor;
    int         m_row;
    int         m_run;
    int         m_set[4];
    int         m_vz;
    int         m_hz;
    int         m_fft;

    ui_top #(
        .DEBOUNCE_CYCLES(4)
    ) i_ui_top (
        .clk_50M   (clk_50M),
        .rst_n     (rst_n),
        .key_in    (key_in),
        .mode      (mode),
        .cursor    (cursor),
        .siggen_cfg(siggen_cfg),
        .scope_cfg (scope_cfg),
        .da_data   (da_data)
    );

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;
    end

    task automatic fail_now(input string msg);
        error_count++;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            fail_now($sformatf("Fail at %0t: %s is %0d, expected %0d",
                               $time, name, actual, expected));
        end
    endtask

    always @(posedge clk_50M) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_now("the run did not finish within the cycle limit");
        end
    end

    task automatic apply_model(input int key);
        case (m_mode)
            MODE_TOP: begin
                if (key == K_CONFIRM) begin
                    m_mode = (m_cursor == 0) ? MODE_SIGGEN : MODE_SCOPE;
                end else if (key == K_LEFT) begin
                    m_cursor = (m_cursor + TOP_ENTRIES - 1) % TOP_ENTRIES;
                end else if (key == K_RIGHT) begin
                    m_cursor = (m_cursor + 1) % TOP_ENTRIES;
                end
            end
            MODE_SIGGEN: begin
                if (key == K_QUIT) begin
                    m_mode   = MODE_TOP;
                    m_cursor = 0;
                    m_row    = 0;
                    m_run    = 0;
                    foreach (m_set[i]) m_set[i] = 0;
                end else if (key == K_UP) begin
                    m_row = (m_row == 0) ? LAST_ROW : m_row - 1;
                end else if (key == K_DOWN) begin
                    m_row = (m_row == LAST_ROW) ? 0 : m_row + 1;
                end else if (m_row < LAST_ROW && key == K_LEFT) begin
                    m_set[m_row] = (m_set[m_row] + 3) % 4;
                end else if (m_row < LAST_ROW && key == K_RIGHT) begin
                    m_set[m_row] = (m_set[m_row] + 1) % 4;
                end else if (m_row == LAST_ROW && key == K_CONFIRM) begin
                    m_run = 1;
                end
            end
            MODE_SCOPE: begin
                if (key == K_QUIT) begin
                    m_mode   = MODE_TOP;
                    m_cursor = 0;
                    m_fft    = 0;
                    m_vz     = 0;
                    m_hz     = 0;
                end else if (key == K_CONFIRM) begin
                    m_fft = 1;
                    m_vz  = 0;
                    m_hz  = 0;
                end else if (m_fft == 0) begin
                    case (key)
                        K_UP: m_vz = (m_vz + 1) % ZOOM_STEPS;
                        K_DOWN: m_vz = (m_vz + ZOOM_STEPS - 1) % ZOOM_STEPS;
                        K_LEFT: m_hz = (m_hz + ZOOM_STEPS - 1) % ZOOM_STEPS;
                        K_RIGHT: m_hz = (m_hz + 1) % ZOOM_STEPS;
                        default: begin
                        end
                    endcase
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_outputs();
        sample_t limit;
        limit = 8'hff >> m_set[1];
        check_value("mode", int'(mode), int'(m_mode));
        check_value("cursor", int'(cursor), m_cursor);
        check_value("siggen_cfg.row", int'(siggen_cfg.row), m_row);
        check_value("siggen_cfg.wave", int'(siggen_cfg.wave), m_set[0]);
        check_value("siggen_cfg.amp", int'(siggen_cfg.amp), m_set[1]);
        check_value("siggen_cfg.freq", int'(siggen_cfg.freq), m_set[2]);
        check_value("siggen_cfg.phase", int'(siggen_cfg.phase), m_set[3]);
        check_value("siggen_cfg.run", int'(siggen_cfg.run), m_run);
        check_value("scope_cfg.v_zoom", int'(scope_cfg.v_zoom), m_vz);
        check_value("scope_cfg.h_zoom", int'(scope_cfg.h_zoom), m_hz);
        check_value("scope_cfg.fft_on", int'(scope_cfg.fft_on), m_fft);
        if (m_run == 0) begin
            check_value("da_data", int'(da_data), 0);
        end else if (m_set[0] == 3) begin
            if (da_data != 8'd0 && da_data != limit) begin
                fail_now($sformatf("Fail at %0t: da_data is %0d, expected 0 or %0d",
                                   $time, da_data, limit));
            end
        end else if (da_data > limit) begin
            fail_now($sformatf("Fail at %0t: da_data is %0d, expected at most %0d",
                               $time, da_data, limit));
        end
    endtask

    initial begin
        int key;
        rst_n    = 1'b0;
        key_in   = 6'h3f;
        seed     = 32'hb9d9;
        m_mode   = MODE_TOP;
        m_cursor = 0;
        repeat (4) @(posedge clk_50M);
        @(negedge clk_50M);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_50M);
        check_outputs();

        // one key down, then all keys up until the release event settles
        for (int i = 0; i < N_EVENTS; i++) begin
            key    = $unsigned($random(seed)) % 6;
            key_in = ~(6'b1 << key);
            repeat (PRESS_CYCLES) @(negedge clk_50M);
            key_in = 6'h3f;
            apply_model(key);
            repeat (IDLE_CYCLES) @(negedge clk_50M);
            check_outputs();
        end

        if (error_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "errors were found");
        end
    end

endmodule

// ==== test/tb_ui_top_props.sv ====
`timescale 1ns/1ps

module tb_ui_top_props #(
    parameter int KIND = 0
) (
    input logic                clk_50M,
    input logic                rst_n,
    input ui_pkg::menu_mode_t  mode,
    input ui_pkg::siggen_cfg_t siggen_cfg,
    input ui_pkg::scope_cfg_t  scope_cfg,
    input ui_pkg::sample_t     sample
);

    import ui_pkg::*;

    // kind 0 siggen panel, 1 scope panel, 2 generator
    if (KIND == 0) begin : g_siggen
        mode_legal: assert property (@(posedge clk_50M) disable iff (!rst_n)
            mode inside {MODE_TOP, MODE_SIGGEN, MODE_SCOPE})
            else $error("mode holds an unused encoding");
        siggen_clear: assert property (@(posedge clk_50M) disable iff (!rst_n)
            mode != MODE_SIGGEN |=> siggen_cfg == '0)
            else $error("siggen settings not cleared after leaving the mode");
    end else if (KIND == 1) begin : g_scope
        scope_clear: assert property (@(posedge clk_50M) disable iff (!rst_n)
            mode != MODE_SCOPE |=> scope_cfg == '0)
            else $error("scope settings not cleared after leaving the mode");
        fft_zoom: assert property (@(posedge clk_50M) disable iff (!rst_n)
            scope_cfg.fft_on |-> (scope_cfg.v_zoom == '0 && scope_cfg.h_zoom == '0))
            else $error("zoom nonzero while fft is on");
    end else begin : g_dds
        idle_zero: assert property (@(posedge clk_50M) disable iff (!rst_n)
            !siggen_cfg.run |=> sample == '0)
            else $error("generator output nonzero while stopped");
    end

endmodule

bind siggen_panel tb_ui_top_props #(.KIND(0)) u_props (.clk_50M(clk_50M), .rst_n(rst_n),
    .mode(mode), .siggen_cfg(cfg), .scope_cfg('0), .sample('0));

bind scope_panel tb_ui_top_props #(.KIND(1)) u_props (.clk_50M(clk_50M), .rst_n(rst_n),
    .mode(mode), .siggen_cfg('0), .scope_cfg(cfg), .sample('0));

bind wave_dds tb_ui_top_props #(.KIND(2)) u_props (.clk_50M(clk_50M), .rst_n(rst_n),
    .mode(ui_pkg::MODE_TOP), .siggen_cfg(cfg), .scope_cfg('0), .sample(sample));

// ==== vlog.f ====
design/ui_pkg.sv
design/key_debounce.sv
design/menu_ctrl.sv
design/siggen_panel.sv
design/scope_panel.sv
design/wave_dds.sv
design/ui_top.sv
test/tb_ui_top_props.sv
test/tb_ui_top.sv
